/* verif/ic_stimulus.txt */
// Per master, masters 0 to 3 left to right: req wen addr wdata bank
// Hex fields; bank is the expected hashed bank index of addr
0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
1 1 010 11111111 1   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
1 1 014 22222222 0   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
1 0 010 00000000 1   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
1 0 014 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
1 1 100 a0000000 0   1 1 110 a1111111 1   1 1 120 a2222222 2   1 1 130 a3333333 3
1 0 130 00000000 3   1 0 120 00000000 2   1 0 110 00000000 1   1 0 100 00000000 0
1 1 040 c0c0c0c0 0   1 1 080 c1c1c1c1 0   1 1 0c0 c2c2c2c2 0   1 1 200 c3c3c3c3 0
1 0 200 00000000 0   1 0 0c0 00000000 0   1 0 080 00000000 0   1 0 040 00000000 0
0 0 000 00000000 0   1 1 008 d1d1d1d1 2   1 1 020 d2d2d2d2 2   1 0 088 00000000 2
1 0 008 00000000 2   1 0 020 00000000 2   1 0 010 00000000 1   1 0 014 00000000 0
0 0 000 00000000 0   0 0 000 00000000 0   1 1 0a0 e2e2e2e2 2   1 0 0a0 00000000 2
0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0   1 0 0a0 00000000 2
1 0 3c4 00000000 1   1 0 3d4 00000000 0   1 0 3e4 00000000 3   1 0 3f4 00000000 2
1 1 ffff0107 5a5a5a5a 1   0 0 000 00000000 0   0 0 000 00000000 0   0 0 000 00000000 0
0 0 000 00000000 0   1 0 104 00000000 1   0 0 000 00000000 0   0 0 000 00000000 0
0 0 000 00000000 0   1 1 00c f1f1f1f1 3   0 0 000 00000000 0   1 1 04c f3f3f3f3 3
0 0 000 00000000 0   1 0 04c 00000000 3   0 0 000 00000000 0   1 0 00c 00000000 3
1 0 040 00000000 0   1 0 200 00000000 0   1 0 080 00000000 0   1 0 0c0 00000000 0

/* vlog.f */
+incdir+include
rtl/ic_pkg.sv
rtl/addr_interleave.sv
rtl/address_decoder_req.sv
rtl/response_tree.sv
rtl/response_block.sv
rtl/bank_arbiter.sv
rtl/tcdm_bank_array.sv
rtl/log_interconnect_top.sv
verif/tb_log_interconnect.sv

/* verif/tb_log_interconnect.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module tb_log_interconnect
    import ic_pkg::*;
();

    localparam int unsigned CLK_HALF       = 20;
    localparam int unsigned DRIVE_DELAY    = 2;
    localparam int unsigned RESET_CYCLES   = 3;
    localparam int unsigned N_LINES        = 20;
    localparam int unsigned N_FIELDS       = 5;
    localparam int unsigned STIM_LEN       = N_LINES * `IC_N_MASTER * N_FIELDS;
    localparam int unsigned N_WORDS        = `IC_N_BANK << `IC_ROW_WIDTH;
    localparam int unsigned FILL_STEPS     = N_WORDS / `IC_N_MASTER;
    localparam int unsigned TIMEOUT_CYCLES = 40 * N_LINES + 2 * FILL_STEPS + 16;

    logic                                    clk;
    logic                                    rst_n_i;
    logic [`IC_N_MASTER-1:0]                 data_req_i;
    logic [`IC_N_MASTER-1:0]                 data_wen_i;
    logic [`IC_N_MASTER-1:0][`IC_ADDR_WIDTH-1:0] data_add_i;
    ic_data_t [`IC_N_MASTER-1:0]             data_wdata_i;
    logic [`IC_N_MASTER-1:0]                 data_gnt_o;
    logic [`IC_N_MASTER-1:0]                 data_r_valid_o;
    ic_data_t [`IC_N_MASTER-1:0]             data_r_rdata_o;

    // Stimulus words, five per master per line
    logic [31:0] stim_mem [STIM_LEN];

    // Reference flat word memory and one pointer per bank
    ic_data_t                mem_model [N_WORDS];
    int unsigned             ptr_model [`IC_N_BANK];
    logic [`IC_N_MASTER-1:0] pending;
    logic [`IC_N_MASTER-1:0] exp_rvalid;
    logic [`IC_N_MASTER-1:0] exp_read;
    ic_data_t                exp_rdata [`IC_N_MASTER];

    int unsigned gnt_errs;
    int unsigned rvalid_errs;
    int unsigned rdata_errs;
    int unsigned map_errs;
    int unsigned load_errs;
    int unsigned cycle_cnt;
    integer      seed;

    log_interconnect_top log_interconnect_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .data_req_i     (data_req_i),
        .data_wen_i     (data_wen_i),
        .data_add_i     (data_add_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_r_valid_o (data_r_valid_o),
        .data_r_rdata_o (data_r_rdata_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////
    // Address map reference
    ////////////////////////////////////////

    // Word bits 2..9 of the byte address
    function automatic int unsigned word_of(input logic [`IC_ADDR_WIDTH-1:0] addr);
        return (addr >> 2) % N_WORDS;
    endfunction

    // Low bank digit, folded with the next digit when hashed
    function automatic int unsigned bank_of(input logic [`IC_ADDR_WIDTH-1:0] addr);
        int unsigned w;
        w = word_of(addr);
        if (`IC_HASH_EN != 0)
            return (w % `IC_N_BANK) ^ ((w / `IC_N_BANK) % `IC_N_BANK);
        return w % `IC_N_BANK;
    endfunction

    ////////////////////////////////////////
    // Per-cycle compare at the falling edge
    ////////////////////////////////////////

    task automatic check_cycle();
        logic [`IC_N_MASTER-1:0] exp_gnt;
        int unsigned             idx;
        int unsigned             next_ptr;
        logic                    found;
        int unsigned             w;

        // Responses owed from last cycle's grants
        for (int m = 0; m < `IC_N_MASTER; m++)
        begin
            if (data_r_valid_o[m] !== exp_rvalid[m])
            begin
                rvalid_errs++;
                $display("ERR %0t: master %0d r_valid %b, expected %b",
                         $time, m, data_r_valid_o[m], exp_rvalid[m]);
            end
            else if (exp_rvalid[m] && exp_read[m] && data_r_rdata_o[m] !== exp_rdata[m])
            begin
                rdata_errs++;
                $display("ERR %0t: master %0d rdata %h, expected %h",
                         $time, m, data_r_rdata_o[m], exp_rdata[m]);
            end
        end

        // Round-robin winner per bank
        exp_gnt = '0;
        for (int b = 0; b < `IC_N_BANK; b++)
        begin
            found    = 1'b0;
            next_ptr = ptr_model[b];
            for (int k = 0; k < `IC_N_MASTER; k++)
            begin
                idx = (ptr_model[b] + k) % `IC_N_MASTER;
                if (!found && pending[idx] && bank_of(data_add_i[idx]) == b)
                begin
                    found        = 1'b1;
                    exp_gnt[idx] = 1'b1;
                    next_ptr     = (idx + 1) % `IC_N_MASTER;
                end
            end
            ptr_model[b] = next_ptr;
        end

        if (data_gnt_o !== exp_gnt)
        begin
            gnt_errs++;
            $display("ERR %0t: gnt %b, expected %b", $time, data_gnt_o, exp_gnt);
        end

        // Transfers on the coming edge
        // At most one master per bank, so one word is never read and written together
        for (int m = 0; m < `IC_N_MASTER; m++)
        begin
            exp_rvalid[m] = exp_gnt[m];
            exp_read[m]   = !data_wen_i[m];
            if (exp_gnt[m])
            begin
                w            = word_of(data_add_i[m]);
                exp_rdata[m] = mem_model[w];
                if (data_wen_i[m])
                    mem_model[w] = data_wdata_i[m];
            end
            // Master keeps its fields until the DUT grants it
            if (data_gnt_o[m] === 1'b1)
                pending[m] = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////

    task automatic wait_drive_point();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_and_check();
        data_req_i = pending;
        @(negedge clk);
        check_cycle();
    endtask

    task automatic run_cycle();
        wait_drive_point();
        drive_and_check();
    endtask

    // Held fields stay put until each master sees its grant
    task automatic issue_and_wait();
        drive_and_check();
        while (pending != '0)
            run_cycle();
    endtask

    // Every word gets a random value, one distinct bank per master
    task automatic fill_memory();
        for (int k = 0; k < FILL_STEPS; k++)
        begin
            wait_drive_point();
            for (int m = 0; m < `IC_N_MASTER; m++)
            begin
                data_wen_i[m]   = 1'b1;
                data_add_i[m]   = `IC_ADDR_WIDTH'((k * `IC_N_MASTER + m) * 4);
                data_wdata_i[m] = $random(seed);
                pending[m]      = 1'b1;
            end
            issue_and_wait();
        end
    endtask

    task automatic apply_line(input int unsigned line);
        int unsigned base;

        wait_drive_point();
        for (int m = 0; m < `IC_N_MASTER; m++)
        begin
            base            = (line * `IC_N_MASTER + m) * N_FIELDS;
            pending[m]      = stim_mem[base][0];
            data_wen_i[m]   = stim_mem[base+1][0];
            data_add_i[m]   = stim_mem[base+2];
            data_wdata_i[m] = stim_mem[base+3];
            // Expected bank column against the hashed map
            if (pending[m] && stim_mem[base+4] != bank_of(stim_mem[base+2]))
            begin
                map_errs++;
                $display("ERR %0t: line %0d master %0d bank %0d, file says %0d",
                         $time, line, m, bank_of(stim_mem[base+2]), stim_mem[base+4]);
            end
        end
        issue_and_wait();
    endtask

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timed out waiting for grants after %0d cycles", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        seed         = 10;
        gnt_errs     = 0;
        rvalid_errs  = 0;
        rdata_errs   = 0;
        map_errs     = 0;
        load_errs    = 0;
        pending      = '0;
        exp_rvalid   = '0;
        exp_read     = '0;
        rst_n_i      = 1'b0;
        data_req_i   = '0;
        data_wen_i   = '0;
        data_add_i   = '0;
        data_wdata_i = '0;
        for (int b = 0; b < `IC_N_BANK; b++)
            ptr_model[b] = 0;

        $readmemh("verif/ic_stimulus.txt", stim_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        if ($isunknown(stim_mem[STIM_LEN-1]))
        begin
            load_errs++;
            $display("Stimulus file verif/ic_stimulus.txt is missing or too short");
        end
        else
        begin
            // Quiet bus right after reset
            repeat (2) run_cycle();
            fill_memory();
            for (int i = 0; i < N_LINES; i++)
                apply_line(i);
            // Last response plus one idle cycle
            repeat (2) run_cycle();
        end

        $display("Errors: gnt %0d, r_valid %0d, rdata %0d, bank map %0d, load %0d",
                 gnt_errs, rvalid_errs, rdata_errs, map_errs, load_errs);
        if (gnt_errs + rvalid_errs + rdata_errs + map_errs + load_errs == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* rtl/log_interconnect_top.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module log_interconnect_top
    import ic_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n_i,

    // Master request ports
    input  logic [`IC_N_MASTER-1:0]                 data_req_i,
    input  logic [`IC_N_MASTER-1:0]                 data_wen_i,
    input  logic [`IC_N_MASTER-1:0][`IC_ADDR_WIDTH-1:0] data_add_i,
    input  ic_data_t [`IC_N_MASTER-1:0]             data_wdata_i,
    output logic [`IC_N_MASTER-1:0]                 data_gnt_o,

    // Master response ports
    output logic [`IC_N_MASTER-1:0]                 data_r_valid_o,
    output ic_data_t [`IC_N_MASTER-1:0]             data_r_rdata_o
);

    // Address split per master
    ic_rout_t [`IC_N_MASTER-1:0]                 rout;
    ic_row_t  [`IC_N_MASTER-1:0]                 row;

    // Master to bank crossbar wiring
    logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     bank_req;
    logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     bank_gnt;
    ic_master_id_t [`IC_N_MASTER-1:0]            master_id;
    logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     bank_r_valid;
    ic_data_t [`IC_N_MASTER-1:0][`IC_N_BANK-1:0] bank_r_rdata;

    addr_interleave addr_interleave_inst (
        .data_add_i (data_add_i),
        .rout_o     (rout),
        .row_o      (row)
    );

    genvar m;

    generate
        for (m = 0; m < `IC_N_MASTER; m++)
        begin : g_master
            response_block #(
                .ID (m)
            ) response_block_inst (
                .data_req_i     (data_req_i[m]),
                .routing_addr_i (rout[m]),
                .data_gnt_o     (data_gnt_o[m]),
                .data_gnt_i     (bank_gnt[m]),
                .data_req_o     (bank_req[m]),
                .data_id_o      (master_id[m]),
                .data_r_valid_i (bank_r_valid[m]),
                .data_r_rdata_i (bank_r_rdata[m]),
                .data_r_valid_o (data_r_valid_o[m]),
                .data_r_rdata_o (data_r_rdata_o[m])
            );
        end
    endgenerate

    tcdm_bank_array tcdm_bank_array_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .data_req_i     (bank_req),
        .data_id_i      (master_id),
        .data_wen_i     (data_wen_i),
        .row_i          (row),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (bank_gnt),
        .data_r_valid_o (bank_r_valid),
        .data_r_rdata_o (bank_r_rdata)
    );

endmodule

/* rtl/tcdm_bank_array.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module tcdm_bank_array
    import ic_pkg::*;
(
    input  logic                                        clk,
    input  logic                                        rst_n_i,

    // One-hot bank request vector per master
    input  logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     data_req_i,
    input  ic_master_id_t [`IC_N_MASTER-1:0]            data_id_i,

    // Request payload per master
    input  logic [`IC_N_MASTER-1:0]                     data_wen_i,
    input  ic_row_t [`IC_N_MASTER-1:0]                  row_i,
    input  ic_data_t [`IC_N_MASTER-1:0]                 data_wdata_i,

    // Grant vector per master
    output logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     data_gnt_o,

    // Response vectors per master, one slot per bank
    output logic [`IC_N_MASTER-1:0][`IC_N_BANK-1:0]     data_r_valid_o,
    output ic_data_t [`IC_N_MASTER-1:0][`IC_N_BANK-1:0] data_r_rdata_o
);

    // Words per bank
    localparam int unsigned DEPTH = 1 << `IC_ROW_WIDTH;

    // Bank-indexed views, transposed at the end
    ic_master_id_t bank_gnt      [`IC_N_BANK];
    ic_master_id_t bank_r_id     [`IC_N_BANK];
    logic          bank_rvalid_q [`IC_N_BANK];
    ic_data_t      bank_rdata_q  [`IC_N_BANK];

    genvar b;

    generate
        for (b = 0; b < `IC_N_BANK; b++)
        begin : g_bank
            ic_master_id_t bank_req;
            ic_master_id_t bank_winner;
            ic_row_t       mem_row;
            logic          mem_wen;
            ic_data_t      mem_wdata;
            ic_data_t      mem [DEPTH];

            // Collect the masters aiming at this bank
            // Each request carries its own one-hot tag
            always_comb
            begin
                bank_req = '0;
                for (int m = 0; m < `IC_N_MASTER; m++)
                begin
                    if (data_req_i[m][b])
                        bank_req = bank_req | data_id_i[m];
                end
            end

            bank_arbiter bank_arbiter_inst (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .req_i    (bank_req),
                .gnt_o    (bank_gnt[b]),
                .winner_o (bank_winner),
                .r_id_o   (bank_r_id[b])
            );

            ////////////////////////////////////////
            // Winner payload mux
            ////////////////////////////////////////

            always_comb
            begin
                mem_row   = '0;
                mem_wen   = 1'b0;
                mem_wdata = '0;
                for (int m = 0; m < `IC_N_MASTER; m++)
                begin
                    if (bank_winner[m])
                    begin
                        mem_row   = row_i[m];
                        mem_wen   = data_wen_i[m];
                        mem_wdata = data_wdata_i[m];
                    end
                end
            end

            // Single-port memory
            // Read data is the old word, also on a write
            always_ff @(posedge clk)
            begin
                if (|bank_gnt[b])
                begin
                    bank_rdata_q[b] <= mem[mem_row];
                    if (mem_wen)
                        mem[mem_row] <= mem_wdata;
                end
            end

            // Response one cycle after each grant
            always_ff @(posedge clk or negedge rst_n_i)
            begin
                if (!rst_n_i)
                    bank_rvalid_q[b] <= 1'b0;
                else
                    bank_rvalid_q[b] <= |bank_gnt[b];
            end
        end
    endgenerate

    // Bank-major to master-major
    // Valid goes only to the master the arbiter recorded
    always_comb
    begin
        for (int m = 0; m < `IC_N_MASTER; m++)
        begin
            for (int n = 0; n < `IC_N_BANK; n++)
            begin
                data_gnt_o[m][n]     = bank_gnt[n][m];
                data_r_valid_o[m][n] = bank_rvalid_q[n] & bank_r_id[n][m];
                data_r_rdata_o[m][n] = bank_rdata_q[n];
            end
        end
    end

endmodule

/* rtl/bank_arbiter.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module bank_arbiter
    import ic_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,

    // Requests toward this bank, one bit per master
    input  logic [`IC_N_MASTER-1:0] req_i,

    // Grant back to the masters
    output logic [`IC_N_MASTER-1:0] gnt_o,

    // Winner of this cycle, drives the bank mux
    output ic_master_id_t           winner_o,

    // Winner of the previous grant, routes the response
    output ic_master_id_t           r_id_o
);

    // Pointer width, at least one bit
    localparam int unsigned PTR_W = (`IC_N_MASTER > 1) ? $clog2(`IC_N_MASTER) : 1;

    // Highest priority master for the next grant
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_d;

    ic_master_id_t    winner;
    ic_master_id_t    r_id_q;

    ////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////

    // Scan from the pointer, wrapping around
    // First requester found wins
    always_comb
    begin
        int unsigned idx;
        logic        found;

        winner = '0;
        ptr_d  = ptr_q;
        found  = 1'b0;
        for (int k = 0; k < `IC_N_MASTER; k++)
        begin
            idx = (ptr_q + k) % `IC_N_MASTER;
            if (!found && req_i[idx])
            begin
                found       = 1'b1;
                winner[idx] = 1'b1;
                // Winner drops to lowest priority
                ptr_d       = PTR_W'((idx + 1) % `IC_N_MASTER);
            end
        end
    end

    assign gnt_o    = winner;
    assign winner_o = winner;

    ////////////////////////////////////////
    // Pointer and response ID
    ////////////////////////////////////////

    // Both move only on a grant edge
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ptr_q  <= '0;
            r_id_q <= '0;
        end
        else if (|winner)
        begin
            ptr_q  <= ptr_d;
            r_id_q <= winner;
        end
    end

    assign r_id_o = r_id_q;

endmodule

/* rtl/response_block.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module response_block
    import ic_pkg::*;
#(
    // Master index of this block
    parameter int unsigned ID = 0
)
(
    // Request from the master
    input  logic                      data_req_i,
    input  ic_rout_t                  routing_addr_i,
    output logic                      data_gnt_o,

    // Bank side request and grant
    input  logic [`IC_N_BANK-1:0]     data_gnt_i,
    output logic [`IC_N_BANK-1:0]     data_req_o,
    output ic_master_id_t             data_id_o,

    // Responses from every bank
    input  logic [`IC_N_BANK-1:0]     data_r_valid_i,
    input  ic_data_t [`IC_N_BANK-1:0] data_r_rdata_i,

    // Response to the master
    output logic                      data_r_valid_o,
    output ic_data_t                  data_r_rdata_o
);

    ////////////////////////////////////////
    // Request path
    ////////////////////////////////////////

    address_decoder_req #(
        .ID (ID)
    ) address_decoder_req_inst (
        .data_req_i     (data_req_i),
        .routing_addr_i (routing_addr_i),
        .data_gnt_i     (data_gnt_i),
        .data_gnt_o     (data_gnt_o),
        .data_req_o     (data_req_o),
        .data_id_o      (data_id_o)
    );

    ////////////////////////////////////////
    // Response path
    ////////////////////////////////////////

    // Collapse per-bank answers into one
    response_tree #(
        .N_BANK (`IC_N_BANK)
    ) response_tree_inst (
        .data_r_valid_i (data_r_valid_i),
        .data_r_rdata_i (data_r_rdata_i),
        .data_r_valid_o (data_r_valid_o),
        .data_r_rdata_o (data_r_rdata_o)
    );

endmodule

/* rtl/response_tree.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module response_tree
    import ic_pkg::*;
#(
    // Number of leaves in the tree
    parameter int unsigned N_BANK = `IC_N_BANK
)
(
    // Per-bank responses for one master
    input  logic [N_BANK-1:0]     data_r_valid_i,
    input  ic_data_t [N_BANK-1:0] data_r_rdata_i,

    // Merged response
    output logic                  data_r_valid_o,
    output ic_data_t              data_r_rdata_o
);

    // Heap layout of the tree
    // Root at 0, children of k at 2k+1 and 2k+2
    // Leaves occupy N_BANK-1 upwards
    localparam int unsigned N_NODE = 2 * N_BANK - 1;

    logic     node_valid [N_NODE];
    ic_data_t node_rdata [N_NODE];

    genvar i;

    generate
        ////////////////////////////////////////
        // Leaves
        ////////////////////////////////////////
        for (i = 0; i < N_BANK; i++)
        begin : g_leaf
            assign node_valid[N_BANK-1+i] = data_r_valid_i[i];
            assign node_rdata[N_BANK-1+i] = data_r_rdata_i[i];
        end

        ////////////////////////////////////////
        // Inner nodes
        ////////////////////////////////////////
        for (i = 0; i < N_BANK - 1; i++)
        begin : g_node
            // Either child valid makes the node valid
            assign node_valid[i] = node_valid[2*i+1] | node_valid[2*i+2];

            // Data of the valid side
            // At most one bank answers per cycle, so the right side is the default
            assign node_rdata[i] = node_valid[2*i+1] ? node_rdata[2*i+1]
                                                     : node_rdata[2*i+2];
        end
    endgenerate

    // Root drives the master response
    assign data_r_valid_o = node_valid[0];
    assign data_r_rdata_o = node_rdata[0];

endmodule

/* rtl/address_decoder_req.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module address_decoder_req
    import ic_pkg::*;
#(
    // Index of the owning master
    parameter int unsigned ID = 0
)
(
    // Master side
    input  logic                  data_req_i,
    input  ic_rout_t              routing_addr_i,
    output logic                  data_gnt_o,

    // Bank side, one bit per bank
    input  logic [`IC_N_BANK-1:0] data_gnt_i,
    output logic [`IC_N_BANK-1:0] data_req_o,

    // Tag sent along with the request
    output ic_master_id_t         data_id_o
);

    // One-hot tag of this master
    localparam ic_master_id_t MASTER_ID = ic_master_id_t'(1) << ID;

    // Decoded bank select, before gating by req
    logic [`IC_N_BANK-1:0] bank_sel;

    always_comb
    begin
        bank_sel                 = '0;
        bank_sel[routing_addr_i] = 1'b1;
    end

    // Only one bank sees each request
    assign data_req_o = data_req_i ? bank_sel : '0;

    // Fold the bank grants back
    // Mask keeps grants of other banks out
    assign data_gnt_o = |(data_gnt_i & data_req_o);

    // Tag follows the request into the bank array
    assign data_id_o  = MASTER_ID;

endmodule

/* rtl/addr_interleave.sv */
`timescale 1ns/1ns
`include "ic_config.svh"

module addr_interleave
    import ic_pkg::*;
(
    // Byte addresses, one per master
    input  logic [`IC_N_MASTER-1:0][`IC_ADDR_WIDTH-1:0] data_add_i,

    // Bank index toward the response blocks
    output ic_rout_t [`IC_N_MASTER-1:0]                 rout_o,

    // Row inside the selected bank
    output ic_row_t  [`IC_N_MASTER-1:0]                 row_o
);

    // Word view of each master address
    ic_word_addr_u word_addr [`IC_N_MASTER];

    always_comb
    begin
        for (int m = 0; m < `IC_N_MASTER; m++)
        begin
            // Byte offset and upper bits fall outside the memory map
            word_addr[m].word_idx = data_add_i[m][IC_WORD_WIDTH+1:2];

            // Row is taken straight from the upper word bits
            row_o[m] = word_addr[m].rb.row;

            // Fold the low row bits into the bank field
            // Strides of 4 or 8 words no longer pile on one bank
            if (`IC_HASH_EN != 0)
            begin
                rout_o[m] = word_addr[m].rb.bank
                          ^ word_addr[m].word_idx[2*`IC_ROUT_WIDTH-1:`IC_ROUT_WIDTH];
            end
            else
            begin
                // Plain interleaving on the low word bits
                rout_o[m] = word_addr[m].rb.bank;
            end
        end
    end

    // Row plus bank stays one-to-one with the word index,
    // the XOR term comes from row bits, which travel unchanged

endmodule

/* rtl/ic_pkg.sv */
`include "ic_config.svh"

package ic_pkg;

    // Word address seen by the interconnect
    // Row field on top, bank field below
    localparam int unsigned IC_WORD_WIDTH = `IC_ROW_WIDTH + `IC_ROUT_WIDTH;

    ////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////

    typedef logic [`IC_DATA_WIDTH-1:0] ic_data_t;
    typedef logic [`IC_ROUT_WIDTH-1:0] ic_rout_t;
    typedef logic [`IC_ROW_WIDTH-1:0]  ic_row_t;

    // One-hot tag of the requesting master
    typedef logic [`IC_N_MASTER-1:0]   ic_master_id_t;

    ////////////////////////////////////////
    // Word address views
    ////////////////////////////////////////

    // Row and bank split of one word
    typedef struct packed {
        ic_row_t  row;
        ic_rout_t bank;
    } ic_row_bank_t;

    // Same word, linear index or row/bank pair
    typedef union packed {
        logic [IC_WORD_WIDTH-1:0] word_idx;
        ic_row_bank_t             rb;
    } ic_word_addr_u;

endpackage

/* include/ic_config.svh */
`ifndef IC_CONFIG_SVH
`define IC_CONFIG_SVH

////////////////////////////////////////
// Interconnect dimensions
////////////////////////////////////////

// Masters sharing the data memory
`define IC_N_MASTER    4

// Word-interleaved banks, power of two
`define IC_N_BANK      4

// Data word and master byte address
`define IC_DATA_WIDTH  32
`define IC_ADDR_WIDTH  32

// Row index inside one bank, 64 words deep
`define IC_ROW_WIDTH   6

// Bank index, log2 of IC_N_BANK
`define IC_ROUT_WIDTH  2

// Bank hash on word bits 3..2
// 0 gives plain low-order interleaving
`define IC_HASH_EN     1

`endif
